//--- sources.f
src/uart_cmd_pkg.sv
src/cmd_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_decode.sv
src/reg_exec.sv
src/resp_sender.sv
src/uart_cmd_top.sv
sim/tb_uart_cmd.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_cmd \
    -f sources.f -o sim_uart_cmd && ./obj_dir/sim_uart_cmd > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }

//--- sim/tb_uart_cmd.sv
`timescale 1ns/100ps

module tb_uart_cmd;
    import uart_cmd_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_CMDS    = 50;  // Full commands plus partial frames.
    localparam int WATCHDOG_NS = (NUM_CMDS * 60 + 200) * CLKS_PER_BIT * CLK_PERIOD;

    // Host-side copies of the protocol bytes.
    localparam logic [7:0] CMD_WRITE = 8'h57;
    localparam logic [7:0] CMD_READ  = 8'h52;
    localparam logic [7:0] CMD_ADD   = 8'h41;
    localparam logic [7:0] CMD_XOR   = 8'h58;
    localparam logic [7:0] RESP_OK   = 8'h4B;
    localparam logic [7:0] RESP_ERR  = 8'h45;

    logic       clk;
    logic       rst;
    logic       rx;
    logic       tx;
    logic       busy;
    logic [7:0] model [8];
    integer     seed = 32'hd2bf_cb57;

    uart_cmd_top UUT (
        .clk  (clk),
        .rst  (rst),
        .rx   (rx),
        .tx   (tx),
        .busy (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all commands were answered");
        $display("Test failed");
        $fatal(1);
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [7:0] actual, input logic [7:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is 8'h%02h, expected 8'h%02h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // 8N1 frame, LSB first. Called on a falling edge.
    task automatic send_byte(input logic [7:0] b, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        while (tx !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > 40 * CLKS_PER_BIT)
                abort_run("No start bit seen on tx");
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of the start bit.
        check_eq({7'd0, tx}, 8'd0, "tx at mid start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_eq({7'd0, tx}, 8'd1, "tx stop bit");
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > 2 * CLKS_PER_BIT)
                abort_run("busy stayed high after the response");
        end
    endtask

    // Expected reply from the command rules. Updates the register model.
    task automatic predict(input logic [7:0] op, input logic [7:0] addr,
                           input logic [7:0] data, output logic [7:0] status,
                           output logic [7:0] value);
        logic op_ok;
        op_ok = (op == CMD_WRITE) || (op == CMD_READ) || (op == CMD_ADD) || (op == CMD_XOR);
        if (!op_ok || addr > 8'd7) begin
            status = RESP_ERR;
            value  = 8'h00;
        end else begin
            case (op)
                CMD_WRITE: model[addr[2:0]] = data;
                CMD_ADD:   model[addr[2:0]] = model[addr[2:0]] + data;
                CMD_XOR:   model[addr[2:0]] = model[addr[2:0]] ^ data;
                default:   ;
            endcase
            status = RESP_OK;
            value  = model[addr[2:0]];
        end
    endtask

    task automatic do_command(input logic [7:0] op, input logic [7:0] addr,
                              input logic [7:0] data);
        logic [7:0] exp_status;
        logic [7:0] exp_value;
        logic [7:0] got_status;
        logic [7:0] got_value;
        predict(op, addr, data, exp_status, exp_value);
        fork
            begin
                send_byte(op, 1'b1);
                send_byte(addr, 1'b1);
                send_byte(data, 1'b1);
                check_eq({7'd0, busy}, 8'd1, "busy after third byte");
            end
            begin
                recv_byte(got_status);
                recv_byte(got_value);
            end
        join
        check_eq(got_status, exp_status, $sformatf("status of %02h/%02h", op, addr));
        check_eq(got_value, exp_value, $sformatf("value of %02h/%02h", op, addr));
        check_eq({7'd0, busy}, 8'd1, "busy during last stop bit");
        wait_idle();
    endtask

    task automatic read_after_reset();
        check_eq({7'd0, tx}, 8'd1, "tx after reset");
        check_eq({7'd0, busy}, 8'd0, "busy after reset");
        for (int a = 0; a < 8; a++)
            do_command(CMD_READ, 8'(a), rand_byte());
    endtask

    task automatic write_then_read();
        for (int a = 0; a < 8; a++)
            do_command(CMD_WRITE, 8'(a), rand_byte());
        for (int a = 0; a < 8; a++)
            do_command(CMD_READ, 8'(a), 8'h00);
    endtask

    task automatic add_xor_ops();
        logic [7:0] r;
        for (int n = 0; n < 12; n++) begin
            r = rand_byte();
            do_command(r[0] ? CMD_ADD : CMD_XOR, {5'd0, r[3:1]}, rand_byte());
        end
    endtask

    task automatic bad_command_errors();
        do_command(8'h77, 8'd3, rand_byte());  // Lower case w.
        do_command(8'h00, 8'd5, rand_byte());
        do_command(CMD_READ, 8'd3, 8'h00);
        do_command(CMD_READ, 8'd5, 8'h00);
        do_command(CMD_WRITE, 8'd8, rand_byte());
        do_command(CMD_ADD, 8'hC3, rand_byte());
        do_command(CMD_READ, 8'd0, 8'h00);     // Low bits of both bad addresses.
        do_command(CMD_READ, 8'd3, 8'h00);
    endtask

    task automatic frame_error_recovery();
        send_byte(CMD_WRITE, 1'b1);
        send_byte(8'd2, 1'b1);
        send_byte(rand_byte(), 1'b0);
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        check_eq({7'd0, busy}, 8'd0, "busy after framing error");
        do_command(CMD_WRITE, 8'd2, rand_byte());
        do_command(CMD_READ, 8'd2, 8'h00);
        send_byte(CMD_XOR, 1'b1);
        send_byte(rand_byte(), 1'b0);
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        check_eq({7'd0, busy}, 8'd0, "busy after framing error");
        do_command(CMD_ADD, 8'd6, rand_byte());
        do_command(CMD_READ, 8'd6, 8'h00);
    endtask

    initial begin
        rst = 1'b1;
        rx  = 1'b1;
        for (int i = 0; i < 8; i++)
            model[i] = 8'h00;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        read_after_reset();
        write_then_read();
        add_xor_ops();
        bad_command_errors();
        frame_error_recovery();
        $display("Test passed");
        $finish;
    end

endmodule

//--- src/uart_cmd_top.sv
`timescale 1ns/100ps

module uart_cmd_top (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic tx,
    output logic busy
);
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       frame_err;
    logic       res_valid;
    logic [7:0] res_status;
    logic [7:0] res_value;
    logic [7:0] tx_data;
    logic       tx_data_valid;
    logic       tx_ready;

    cmd_if cmd_bus ();

    uart_rx u_rx (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .frame_err (frame_err)
    );

    cmd_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .frame_err (frame_err),
        .cmd       (cmd_bus.dec)
    );

    reg_exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_bus.exe),
        .res_valid  (res_valid),
        .res_status (res_status),
        .res_value  (res_value)
    );

    resp_sender u_resp (
        .clk           (clk),
        .rst           (rst),
        .res_valid     (res_valid),
        .res_status    (res_status),
        .res_value     (res_value),
        .tx_ready      (tx_ready),
        .tx_data       (tx_data),
        .tx_data_valid (tx_data_valid),
        .busy          (busy)
    );

    uart_tx u_tx (
        .clk           (clk),
        .rst           (rst),
        .tx_data       (tx_data),
        .tx_data_valid (tx_data_valid),
        .tx            (tx),
        .tx_ready      (tx_ready)
    );

endmodule

//--- src/resp_sender.sv
`timescale 1ns/100ps

module resp_sender (
    input  logic       clk,
    input  logic       rst,
    input  logic       res_valid,
    input  logic [7:0] res_status,
    input  logic [7:0] res_value,
    input  logic       tx_ready,
    output logic [7:0] tx_data,
    output logic       tx_data_valid,
    output logic       busy
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_STAT_RAISE,
        S_STAT_WAIT,
        S_VAL_RAISE,
        S_VAL_WAIT,
        S_DONE
    } resp_state_t;

    resp_state_t state;
    logic [7:0]  status_r;
    logic [7:0]  value_r;

    // Raise valid, wait for the transmitter to take it, then wait for idle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:       if (res_valid) state <= S_STAT_RAISE;
                S_STAT_RAISE: if (!tx_ready) state <= S_STAT_WAIT;
                S_STAT_WAIT:  if (tx_ready) state <= S_VAL_RAISE;
                S_VAL_RAISE:  if (!tx_ready) state <= S_VAL_WAIT;
                S_VAL_WAIT:   if (tx_ready) state <= S_DONE;
                default:      state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && res_valid) begin
            status_r <= res_status;
            value_r  <= res_value;
        end
    end

    assign tx_data_valid = (state == S_STAT_RAISE) || (state == S_VAL_RAISE);
    assign tx_data       = (state == S_VAL_RAISE || state == S_VAL_WAIT) ? value_r : status_r;
    assign busy          = (state != S_IDLE);

    // Host must wait for the whole response.
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> !busy)
        else $error("resp_sender: result arrived while a response was in flight");

endmodule

//--- src/reg_exec.sv
`timescale 1ns/100ps

module reg_exec (
    input  logic       clk,
    input  logic       rst,
    cmd_if.exe         cmd,
    output logic       res_valid,
    output logic [7:0] res_status,
    output logic [7:0] res_value
);
    import uart_cmd_pkg::*;

    logic [7:0] regs [NUM_REGS];
    logic [7:0] cur_val;
    logic [7:0] new_val;
    logic       do_cmd;

    assign cur_val = regs[cmd.addr];
    assign do_cmd  = cmd.valid && !cmd.bad;

    always_comb begin
        case (cmd.opcode)
            OP_WRITE: new_val = cmd.data;
            OP_ADD:   new_val = cur_val + cmd.data;  // Wraps mod 256.
            OP_XOR:   new_val = cur_val ^ cmd.data;
            default:  new_val = cur_val;             // Read.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= 8'd0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= cmd.valid;
            if (do_cmd && cmd.opcode != OP_READ)
                regs[cmd.addr] <= new_val;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            res_status <= cmd.bad ? STATUS_ERR : STATUS_OK;
            res_value  <= cmd.bad ? 8'd0 : new_val;
        end
    end

    // Decode must have screened the opcode before execution.
    a_op_known: assert property (@(posedge clk) disable iff (rst)
        (cmd.valid && !cmd.bad) |-> (cmd.opcode inside {OP_WRITE, OP_READ, OP_ADD, OP_XOR}))
        else $error("reg_exec: accepted command with opcode %02h", cmd.opcode);

endmodule

//--- src/cmd_decode.sv
`timescale 1ns/100ps

module cmd_decode (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       frame_err,
    cmd_if.dec         cmd
);
    import uart_cmd_pkg::*;

    logic [1:0] byte_cnt;
    logic [7:0] opcode_r;
    logic [7:0] addr_r;
    logic       op_known;
    logic       last_byte;

    assign last_byte = rx_valid && byte_cnt == 2'd2;

    always_comb begin
        case (opcode_r)
            OP_WRITE, OP_READ, OP_ADD, OP_XOR: op_known = 1'b1;
            default:                           op_known = 1'b0;
        endcase
    end

    // Byte position within the command.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt  <= 2'd0;
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= last_byte;
            if (frame_err)
                byte_cnt <= 2'd0;  // Drop the partial command.
            else if (rx_valid)
                byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && byte_cnt == 2'd0)
            opcode_r <= rx_data;
        if (rx_valid && byte_cnt == 2'd1)
            addr_r <= rx_data;
        if (last_byte) begin
            cmd.opcode <= opcode_t'(opcode_r);
            cmd.addr   <= addr_r[2:0];
            cmd.data   <= rx_data;
            cmd.bad    <= !op_known || (addr_r >= 8'(NUM_REGS));
        end
    end

endmodule

//--- src/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_data_valid,
    output logic       tx,
    output logic       tx_ready
);
    import uart_cmd_pkg::*;

    tx_state_t            state;
    tx_state_t            next_state;
    logic [CLK_CNT_W-1:0] cycle_cnt;
    logic [2:0]           bit_cnt;
    logic                 valid_r0;
    logic                 valid_r1;
    logic                 valid_rise;
    logic                 bit_end;
    logic [7:0]           tx_data_latch;

    assign valid_rise = valid_r0 & ~valid_r1;  // A frame starts on this edge.
    assign bit_end    = (cycle_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_r0 <= 1'b0;
            valid_r1 <= 1'b0;
        end else begin
            valid_r0 <= tx_data_valid;
            valid_r1 <= valid_r0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state <= TX_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            TX_IDLE:  if (valid_rise) next_state = TX_START;
            TX_START: if (bit_end) next_state = TX_DATA;
            TX_DATA:  if (bit_end && bit_cnt == 3'd7) next_state = TX_STOP;
            TX_STOP:  if (bit_end) next_state = TX_IDLE;
            default:  next_state = TX_IDLE;
        endcase
    end

    // Restarts on every state change and on each data bit boundary.
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cycle_cnt <= '0;
        else if (next_state != state || (state == TX_DATA && bit_end))
            cycle_cnt <= '0;
        else
            cycle_cnt <= cycle_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            bit_cnt <= 3'd0;
        else if (next_state == TX_DATA && state != TX_DATA)
            bit_cnt <= 3'd0;
        else if (state == TX_DATA && bit_end)
            bit_cnt <= bit_cnt + 3'd1;
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && next_state == TX_START)
            tx_data_latch <= tx_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx       <= 1'b1;
            tx_ready <= 1'b0;
        end else begin
            case (state)
                TX_START: tx <= 1'b0;
                TX_DATA:  tx <= tx_data_latch[bit_cnt];  // LSB first.
                default:  tx <= 1'b1;
            endcase
            tx_ready <= (state == TX_IDLE);
        end
    end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_err
);
    import uart_cmd_pkg::*;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic                 start_edge;
    logic                 half_bit;
    logic                 bit_end;
    logic [CLK_CNT_W-1:0] cycle_cnt;
    logic [2:0]           bit_cnt;

    // Two-stage synchronizer plus one delay for edge detection.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync;
    assign half_bit   = (cycle_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end    = (cycle_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= RX_IDLE;
            cycle_cnt <= '0;
            bit_cnt   <= 3'd0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cycle_cnt <= '0;
                    if (start_edge)
                        state <= RX_START;
                end
                RX_START: begin
                    if (half_bit) begin
                        cycle_cnt <= '0;
                        bit_cnt   <= 3'd0;
                        // Line back high at mid start bit means a glitch.
                        state     <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cycle_cnt <= '0;
                        bit_cnt   <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cycle_cnt <= '0;
                        state     <= RX_IDLE;
                        rx_valid  <= rx_sync;  // Good stop bit.
                        frame_err <= ~rx_sync;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end)
            rx_data <= {rx_sync, rx_data[7:1]};
    end

endmodule

//--- src/cmd_if.sv
`timescale 1ns/100ps

interface cmd_if;
    import uart_cmd_pkg::*;

    logic       valid;  // One-cycle strobe.
    opcode_t    opcode;
    logic [2:0] addr;
    logic [7:0] data;
    logic       bad;    // Qualified by valid.

    modport dec (
        output valid, opcode, addr, data, bad
    );

    modport exe (
        input valid, opcode, addr, data, bad
    );

endinterface

//--- src/uart_cmd_pkg.sv
package uart_cmd_pkg;

    // Serial timing. The bit time is kept short for simulation.
    localparam int CLKS_PER_BIT = 16;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

    localparam int NUM_REGS = 8;

    // Command opcodes are printable ASCII letters.
    typedef enum logic [7:0] {
        OP_WRITE = 8'h57, // 'W'
        OP_READ  = 8'h52, // 'R'
        OP_ADD   = 8'h41, // 'A'
        OP_XOR   = 8'h58  // 'X'
    } opcode_t;

    // First byte of every response.
    localparam logic [7:0] STATUS_OK  = 8'h4B; // 'K'
    localparam logic [7:0] STATUS_ERR = 8'h45; // 'E'

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage
